//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_axi_lite_demux
FILELIST = axi_lite_demux.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- axi_lite_demux.f
axi_lite_demux_pkg.sv
select_fifo.sv
demux_ctrl.sv
port_mux.sv
req_fanout.sv
axi_lite_demux_top.sv
tb_clk_gen.sv
tb_axi_lite_demux.sv

//--- axi_lite_demux_pkg.sv
package axi_lite_demux_pkg;

  // ------------------------------------------------
  // bus widths and defaults
  // ------------------------------------------------
  localparam int unsigned ADDR_W        = 32;
  localparam int unsigned DATA_W        = 32;
  localparam int unsigned STRB_W        = DATA_W / 8;
  // two select bits cover up to four manager ports
  localparam int unsigned SEL_W         = 2;
  localparam int unsigned NUM_PORTS_DEF = 4;
  localparam int unsigned MAX_TRANS_DEF = 4;

  typedef logic [SEL_W-1:0] select_t;

  // ------------------------------------------------
  // AXI4-Lite channel payloads
  // ------------------------------------------------
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [2:0]        prot;
  } aw_chan_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } w_chan_t;

  typedef struct packed {
    logic [1:0] resp;
  } b_chan_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [2:0]        prot;
  } ar_chan_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
  } r_chan_t;

  // request travels from manager to subordinate
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } req_t;

  typedef struct packed {
    logic     aw_ready;
    logic     w_ready;
    b_chan_t  b;
    logic     b_valid;
    logic     ar_ready;
    r_chan_t  r;
    logic     r_valid;
  } rsp_t;

  // ------------------------------------------------
  // demux control
  // ------------------------------------------------
  typedef struct packed {
    logic w_full;
    logic w_empty;
    logic b_full;
    logic b_empty;
    logic r_full;
    logic r_empty;
  } fifo_stat_t;

  typedef struct packed {
    logic w_push;
    logic w_pop;
    logic b_push;
    logic b_pop;
    logic r_push;
    logic r_pop;
  } fifo_cmd_t;

  // handshake signals seen at the currently selected ports
  typedef struct packed {
    logic aw_ready;
    logic w_ready;
    logic ar_ready;
    logic b_valid;
    logic r_valid;
  } sel_stat_t;

  typedef struct packed {
    logic aw_valid;
    logic w_valid;
    logic ar_valid;
    logic b_ready;
    logic r_ready;
  } fanout_en_t;

endpackage

//--- axi_lite_demux_top.sv
`timescale 1ns/1ps

module axi_lite_demux_top #(
  parameter int unsigned NumPorts = axi_lite_demux_pkg::NUM_PORTS_DEF,
  parameter int unsigned MaxTrans = axi_lite_demux_pkg::MAX_TRANS_DEF
) (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  axi_lite_demux_pkg::req_t                slv_req_i,
  input  axi_lite_demux_pkg::select_t             slv_aw_sel_i,
  input  axi_lite_demux_pkg::select_t             slv_ar_sel_i,
  output axi_lite_demux_pkg::rsp_t                slv_rsp_o,
  output axi_lite_demux_pkg::req_t [NumPorts-1:0] mst_req_o,
  input  axi_lite_demux_pkg::rsp_t [NumPorts-1:0] mst_rsp_i
);

  axi_lite_demux_pkg::fifo_stat_t fifo_stat;
  axi_lite_demux_pkg::fifo_cmd_t  fifo_cmd;
  axi_lite_demux_pkg::sel_stat_t  sel_stat;
  axi_lite_demux_pkg::fanout_en_t fanout_en;
  axi_lite_demux_pkg::select_t    w_sel;
  axi_lite_demux_pkg::select_t    b_sel;
  axi_lite_demux_pkg::select_t    r_sel;
  axi_lite_demux_pkg::b_chan_t    b_chan;
  axi_lite_demux_pkg::r_chan_t    r_chan;

  logic w_full;
  logic w_empty;
  logic b_full;
  logic b_empty;
  logic r_full;
  logic r_empty;
  logic aw_ready;
  logic w_ready;
  logic ar_ready;
  logic b_valid;
  logic r_valid;

  assign fifo_stat = '{w_full, w_empty, b_full, b_empty, r_full, r_empty};

  always_comb begin
    slv_rsp_o          = '0;
    slv_rsp_o.aw_ready = aw_ready;
    slv_rsp_o.w_ready  = w_ready;
    slv_rsp_o.ar_ready = ar_ready;
    slv_rsp_o.b_valid  = b_valid;
    slv_rsp_o.b        = b_chan;
    slv_rsp_o.r_valid  = r_valid;
    slv_rsp_o.r        = r_chan;
  end

  demux_ctrl u_ctrl (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .slv_req_i  (slv_req_i),
    .sel_i      (sel_stat),
    .fifo_i     (fifo_stat),
    .en_o       (fanout_en),
    .fifo_o     (fifo_cmd),
    .aw_ready_o (aw_ready),
    .w_ready_o  (w_ready),
    .ar_ready_o (ar_ready),
    .b_valid_o  (b_valid),
    .r_valid_o  (r_valid)
  );

  // ------------------------------------------------
  // select FIFOs for AW -> W -> B and AR -> R
  // ------------------------------------------------
  select_fifo #(.Depth(MaxTrans)) u_w_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (fifo_cmd.w_push),
    .pop_i   (fifo_cmd.w_pop),
    .data_i  (slv_aw_sel_i),
    .data_o  (w_sel),
    .full_o  (w_full),
    .empty_o (w_empty)
  );

  // records the port of each finished W beat as the B source
  select_fifo #(.Depth(MaxTrans)) u_b_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (fifo_cmd.b_push),
    .pop_i   (fifo_cmd.b_pop),
    .data_i  (w_sel),
    .data_o  (b_sel),
    .full_o  (b_full),
    .empty_o (b_empty)
  );

  select_fifo #(.Depth(MaxTrans)) u_r_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (fifo_cmd.r_push),
    .pop_i   (fifo_cmd.r_pop),
    .data_i  (slv_ar_sel_i),
    .data_o  (r_sel),
    .full_o  (r_full),
    .empty_o (r_empty)
  );

  port_mux #(.NumPorts(NumPorts)) u_mux (
    .mst_rsp_i (mst_rsp_i),
    .aw_sel_i  (slv_aw_sel_i),
    .w_sel_i   (w_sel),
    .ar_sel_i  (slv_ar_sel_i),
    .b_sel_i   (b_sel),
    .r_sel_i   (r_sel),
    .sel_o     (sel_stat),
    .b_o       (b_chan),
    .r_o       (r_chan)
  );

  req_fanout #(.NumPorts(NumPorts)) u_fanout (
    .slv_req_i (slv_req_i),
    .aw_sel_i  (slv_aw_sel_i),
    .w_sel_i   (w_sel),
    .ar_sel_i  (slv_ar_sel_i),
    .b_sel_i   (b_sel),
    .r_sel_i   (r_sel),
    .en_i      (fanout_en),
    .mst_req_o (mst_req_o)
  );

endmodule

//--- demux_ctrl.sv
`timescale 1ns/1ps

module demux_ctrl (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  axi_lite_demux_pkg::req_t       slv_req_i,
  input  axi_lite_demux_pkg::sel_stat_t  sel_i,
  input  axi_lite_demux_pkg::fifo_stat_t fifo_i,
  output axi_lite_demux_pkg::fanout_en_t en_o,
  output axi_lite_demux_pkg::fifo_cmd_t  fifo_o,
  output logic                           aw_ready_o,
  output logic                           w_ready_o,
  output logic                           ar_ready_o,
  output logic                           b_valid_o,
  output logic                           r_valid_o
);

  logic lock_aw_q;
  logic lock_aw_d;
  logic w_open;
  logic ar_open;

  // ------------------------------------------------
  // AW channel
  // ------------------------------------------------
  // the select is pushed on the first offer, the lock keeps the beat
  // offered without a second push until the port takes it
  always_comb begin
    lock_aw_d     = lock_aw_q;
    en_o.aw_valid = 1'b0;
    aw_ready_o    = 1'b0;
    fifo_o.w_push = 1'b0;
    if (lock_aw_q) begin
      en_o.aw_valid = 1'b1;
      if (sel_i.aw_ready) begin
        aw_ready_o = 1'b1;
        lock_aw_d  = 1'b0;
      end
    end else if (slv_req_i.aw_valid && !fifo_i.w_full) begin
      en_o.aw_valid = 1'b1;
      fifo_o.w_push = 1'b1;
      if (sel_i.aw_ready) begin
        aw_ready_o = 1'b1;
      end else begin
        lock_aw_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lock_aw_q <= 1'b0;
    end else begin
      lock_aw_q <= lock_aw_d;
    end
  end

  // ------------------------------------------------
  // W and B channels
  // ------------------------------------------------
  // W needs a target from the W FIFO and room to record the B source
  assign w_open        = ~fifo_i.w_empty & ~fifo_i.b_full;
  assign en_o.w_valid  = w_open & slv_req_i.w_valid;
  assign w_ready_o     = w_open & sel_i.w_ready;
  assign fifo_o.w_pop  = slv_req_i.w_valid & w_ready_o;
  assign fifo_o.b_push = slv_req_i.w_valid & w_ready_o;

  assign b_valid_o     = ~fifo_i.b_empty & sel_i.b_valid;
  assign en_o.b_ready  = ~fifo_i.b_empty & slv_req_i.b_ready;
  assign fifo_o.b_pop  = b_valid_o & slv_req_i.b_ready;

  // ------------------------------------------------
  // AR and R channels
  // ------------------------------------------------
  assign ar_open       = ~fifo_i.r_full;
  assign en_o.ar_valid = ar_open & slv_req_i.ar_valid;
  assign ar_ready_o    = ar_open & sel_i.ar_ready;
  assign fifo_o.r_push = slv_req_i.ar_valid & ar_ready_o;

  // responses only while an open read is on record
  assign r_valid_o     = ~fifo_i.r_empty & sel_i.r_valid;
  assign en_o.r_ready  = ~fifo_i.r_empty & slv_req_i.r_ready;
  assign fifo_o.r_pop  = r_valid_o & slv_req_i.r_ready;

endmodule

//--- port_mux.sv
`timescale 1ns/1ps

module port_mux #(
  parameter int unsigned NumPorts = axi_lite_demux_pkg::NUM_PORTS_DEF
) (
  input  axi_lite_demux_pkg::rsp_t [NumPorts-1:0] mst_rsp_i,
  input  axi_lite_demux_pkg::select_t             aw_sel_i,
  input  axi_lite_demux_pkg::select_t             w_sel_i,
  input  axi_lite_demux_pkg::select_t             ar_sel_i,
  input  axi_lite_demux_pkg::select_t             b_sel_i,
  input  axi_lite_demux_pkg::select_t             r_sel_i,
  output axi_lite_demux_pkg::sel_stat_t           sel_o,
  output axi_lite_demux_pkg::b_chan_t             b_o,
  output axi_lite_demux_pkg::r_chan_t             r_o
);

  // compare against each port index so an unused select value reads zero
  always_comb begin
    sel_o = '0;
    b_o   = '0;
    r_o   = '0;
    for (int unsigned p = 0; p < NumPorts; p++) begin
      if (aw_sel_i == axi_lite_demux_pkg::select_t'(p)) begin
        sel_o.aw_ready = mst_rsp_i[p].aw_ready;
      end
      if (w_sel_i == axi_lite_demux_pkg::select_t'(p)) begin
        sel_o.w_ready = mst_rsp_i[p].w_ready;
      end
      if (ar_sel_i == axi_lite_demux_pkg::select_t'(p)) begin
        sel_o.ar_ready = mst_rsp_i[p].ar_ready;
      end
      // B source is the head of the B FIFO
      if (b_sel_i == axi_lite_demux_pkg::select_t'(p)) begin
        sel_o.b_valid = mst_rsp_i[p].b_valid;
        b_o           = mst_rsp_i[p].b;
      end
      // R source is the head of the R FIFO
      if (r_sel_i == axi_lite_demux_pkg::select_t'(p)) begin
        sel_o.r_valid = mst_rsp_i[p].r_valid;
        r_o           = mst_rsp_i[p].r;
      end
    end
  end

endmodule

//--- req_fanout.sv
`timescale 1ns/1ps

module req_fanout #(
  parameter int unsigned NumPorts = axi_lite_demux_pkg::NUM_PORTS_DEF
) (
  input  axi_lite_demux_pkg::req_t                slv_req_i,
  input  axi_lite_demux_pkg::select_t             aw_sel_i,
  input  axi_lite_demux_pkg::select_t             w_sel_i,
  input  axi_lite_demux_pkg::select_t             ar_sel_i,
  input  axi_lite_demux_pkg::select_t             b_sel_i,
  input  axi_lite_demux_pkg::select_t             r_sel_i,
  input  axi_lite_demux_pkg::fanout_en_t          en_i,
  output axi_lite_demux_pkg::req_t [NumPorts-1:0] mst_req_o
);

  for (genvar p = 0; p < NumPorts; p++) begin : gen_port
    logic hit_aw;
    logic hit_w;
    logic hit_ar;
    logic hit_b;
    logic hit_r;

    assign hit_aw = (aw_sel_i == axi_lite_demux_pkg::select_t'(p));
    assign hit_w  = (w_sel_i == axi_lite_demux_pkg::select_t'(p));
    assign hit_ar = (ar_sel_i == axi_lite_demux_pkg::select_t'(p));
    assign hit_b  = (b_sel_i == axi_lite_demux_pkg::select_t'(p));
    assign hit_r  = (r_sel_i == axi_lite_demux_pkg::select_t'(p));

    // payloads go everywhere, only the valids and readies are steered
    always_comb begin
      mst_req_o[p]          = '0;
      mst_req_o[p].aw       = slv_req_i.aw;
      mst_req_o[p].w        = slv_req_i.w;
      mst_req_o[p].ar       = slv_req_i.ar;
      mst_req_o[p].aw_valid = en_i.aw_valid & hit_aw;
      mst_req_o[p].w_valid  = en_i.w_valid & hit_w;
      mst_req_o[p].ar_valid = en_i.ar_valid & hit_ar;
      mst_req_o[p].b_ready  = en_i.b_ready & hit_b;
      mst_req_o[p].r_ready  = en_i.r_ready & hit_r;
    end
  end

endmodule

//--- select_fifo.sv
`timescale 1ns/1ps

module select_fifo #(
  parameter int unsigned Depth = axi_lite_demux_pkg::MAX_TRANS_DEF
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        push_i,
  input  logic                        pop_i,
  input  axi_lite_demux_pkg::select_t data_i,
  output axi_lite_demux_pkg::select_t data_o,
  output logic                        full_o,
  output logic                        empty_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  axi_lite_demux_pkg::select_t mem_q [Depth];

  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            do_push;
  logic            do_pop;

  assign full_o  = (count_q == CntW'(Depth));
  assign empty_o = (count_q == '0);

  // a push into a full FIFO or a pop from an empty one is dropped
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop keeps the fill level
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (!do_push && do_pop) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

//--- tb_axi_lite_demux.sv
`timescale 1ns/1ps

module tb_axi_lite_demux;

  localparam int NumPorts = 4;
  localparam int MaxTrans = 4;
  localparam int NumTests = 15;
  localparam int Timeout  = 200;
  localparam int DriveDly = 2;

  typedef struct {
    string                       name;
    bit                          is_wr;
    axi_lite_demux_pkg::select_t sel;
    logic [31:0]                 addr;
    logic [31:0]                 data;
    logic [3:0]                  strb;
    int                          stall;
  } test_t;

  logic                                    clk;
  logic                                    rst_n;
  axi_lite_demux_pkg::req_t                slv_req;
  axi_lite_demux_pkg::rsp_t                slv_rsp;
  axi_lite_demux_pkg::req_t [NumPorts-1:0] mst_req;
  axi_lite_demux_pkg::rsp_t [NumPorts-1:0] mst_rsp;
  axi_lite_demux_pkg::select_t             aw_sel;
  axi_lite_demux_pkg::select_t             ar_sel;
  logic [31:0] aw_addr;
  logic [31:0] ar_addr;
  logic [31:0] w_data;
  logic [3:0]  w_strb;
  logic        aw_valid;
  logic        w_valid;
  logic        b_ready;
  logic        ar_valid;
  logic        r_ready;

  test_t       tbl [NumTests];
  int          test_err [NumTests];
  int          exp_b [$];
  int          exp_r [$];
  int          errors;
  int          rd_issued;
  int          rd_done;
  int          cap_hits;
  bit          aborted;
  logic [31:0] lfsr;

  // manager port model state
  int          aw_cnt [NumPorts];
  int          w_cnt [NumPorts];
  int          b_sent [NumPorts];
  logic [31:0] rd_q [NumPorts][$];

  always_comb begin
    slv_req          = '0;
    slv_req.aw.addr  = aw_addr;
    slv_req.aw_valid = aw_valid;
    slv_req.w.data   = w_data;
    slv_req.w.strb   = w_strb;
    slv_req.w_valid  = w_valid;
    slv_req.b_ready  = b_ready;
    slv_req.ar.addr  = ar_addr;
    slv_req.ar_valid = ar_valid;
    slv_req.r_ready  = r_ready;
  end

  tb_clk_gen #(.PeriodNs(40), .RstCycles(2), .DriveNs(DriveDly)) u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  axi_lite_demux_top #(
    .NumPorts (NumPorts),
    .MaxTrans (MaxTrans)
  ) UUT (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .slv_req_i    (slv_req),
    .slv_aw_sel_i (aw_sel),
    .slv_ar_sel_i (ar_sel),
    .slv_rsp_o    (slv_rsp),
    .mst_req_o    (mst_req),
    .mst_rsp_i    (mst_rsp)
  );

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  // 32-bit Galois LFSR stepped once per random bit
  function automatic bit next_rand_bit();
    bit out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) begin
      lfsr = lfsr ^ 32'hD000_0001;
    end
    return out;
  endfunction

  task automatic check_val(input int idx, input string what,
                           input logic [63:0] exp, input logic [63:0] act);
    string name;
    name = (idx < NumTests) ? tbl[idx].name : "reset";
    assert (exp === act) else begin
      $display("ERROR %s %s: expected %0h, actual %0h", name, what, exp, act);
      errors++;
      if (idx < NumTests) begin
        test_err[idx]++;
      end
    end
  endtask

  // which manager ports see a valid on channel 0 (aw), 1 (w) or 2 (ar)
  function automatic logic [NumPorts-1:0] port_valids(input int chan);
    logic [NumPorts-1:0] v;
    for (int p = 0; p < NumPorts; p++) begin
      case (chan)
        0:       v[p] = mst_req[p].aw_valid;
        1:       v[p] = mst_req[p].w_valid;
        default: v[p] = mst_req[p].ar_valid;
      endcase
    end
    return v;
  endfunction

  // valid bit on top followed by data and resp
  function automatic logic [63:0] resp_word(input bit is_rd);
    if (is_rd) begin
      return 64'({slv_rsp.r_valid, slv_rsp.r.data, slv_rsp.r.resp});
    end
    return 64'({slv_rsp.b_valid, 32'h0, slv_rsp.b.resp});
  endfunction

  function automatic bit resp_pending(input bit is_rd);
    if (is_rd) begin
      return (exp_r.size() > 0) && slv_rsp.r_valid;
    end
    return (exp_b.size() > 0) && slv_rsp.b_valid;
  endfunction

  task automatic set_ready(input bit is_rd, input logic val);
    if (is_rd) begin
      r_ready = val;
    end else begin
      b_ready = val;
    end
  endtask

  // --------------------------------------------------
  // stimulus table
  // --------------------------------------------------
  function automatic void fill_table();
    tbl[0]  = '{"wr_port0", 1'b1, 2'd0, 32'h0000_1000, 32'hA5A5_0001, 4'hF, 0};
    tbl[1]  = '{"wr_port1", 1'b1, 2'd1, 32'h1000_2004, 32'h1234_5678, 4'h3, 0};
    tbl[2]  = '{"wr_port2", 1'b1, 2'd2, 32'h2000_3008, 32'hDEAD_BEEF, 4'hC, 3};
    tbl[3]  = '{"wr_port3", 1'b1, 2'd3, 32'h3000_400C, 32'h0F0F_F0F0, 4'h5, 0};
    tbl[4]  = '{"rd_port0", 1'b0, 2'd0, 32'h0000_0100, 32'h0, 4'h0, 0};
    tbl[5]  = '{"rd_port3", 1'b0, 2'd3, 32'h3333_0104, 32'h0, 4'h0, 0};
    tbl[6]  = '{"rd_port1", 1'b0, 2'd1, 32'h1111_0108, 32'h0, 4'h0, 2};
    tbl[7]  = '{"rd_port2", 1'b0, 2'd2, 32'h2222_010C, 32'h0, 4'h0, 0};
    // long r_ready stall so the next reads fill the R FIFO behind it
    tbl[8]  = '{"rd_stall_r", 1'b0, 2'd2, 32'hCAFE_0200, 32'h0, 4'h0, 20};
    tbl[9]  = '{"rd_cap_a", 1'b0, 2'd1, 32'h0000_0204, 32'h0, 4'h0, 0};
    tbl[10] = '{"rd_cap_b", 1'b0, 2'd3, 32'h0000_0208, 32'h0, 4'h0, 0};
    tbl[11] = '{"rd_cap_c", 1'b0, 2'd0, 32'h0000_020C, 32'h0, 4'h0, 0};
    tbl[12] = '{"rd_cap_d", 1'b0, 2'd1, 32'h0000_0210, 32'h0, 4'h0, 0};
    tbl[13] = '{"wr_stall_b", 1'b1, 2'd1, 32'h4000_0010, 32'h5555_AAAA, 4'hF, 6};
    tbl[14] = '{"wr_mixed", 1'b1, 2'd3, 32'h4000_0014, 32'h0123_4567, 4'h9, 0};
  endfunction

  // --------------------------------------------------
  // request side
  // --------------------------------------------------
  task automatic issue_write(input int i);
    bit aw_hit;
    bit w_hit;
    bit aw_done;
    bit w_done;
    aw_done  = 1'b0;
    w_done   = 1'b0;
    aw_sel   = tbl[i].sel;
    aw_addr  = tbl[i].addr;
    w_data   = tbl[i].data;
    w_strb   = tbl[i].strb;
    aw_valid = 1'b1;
    w_valid  = 1'b1;
    exp_b.push_back(i);
    for (int n = 0; !(aw_done && w_done) && !aborted; n++) begin
      @(negedge clk);
      aw_hit = aw_valid && slv_rsp.aw_ready;
      w_hit  = w_valid && slv_rsp.w_ready;
      if (aw_hit) begin
        check_val(i, "aw port", 64'(1) << tbl[i].sel, 64'(port_valids(0)));
        check_val(i, "aw addr", 64'(tbl[i].addr), 64'(mst_req[tbl[i].sel].aw.addr));
      end
      if (w_hit) begin
        check_val(i, "w port", 64'(1) << tbl[i].sel, 64'(port_valids(1)));
        check_val(i, "w data/strb", 64'({tbl[i].data, tbl[i].strb}),
                  64'({mst_req[tbl[i].sel].w.data, mst_req[tbl[i].sel].w.strb}));
      end
      if (n == Timeout) begin
        $display("timeout: write %s was never accepted", tbl[i].name);
        errors++;
        aborted = 1'b1;
      end
      @(posedge clk);
      #(DriveDly);
      if (aw_hit) begin
        aw_valid = 1'b0;
        aw_done  = 1'b1;
      end
      if (w_hit) begin
        w_valid = 1'b0;
        w_done  = 1'b1;
      end
    end
  endtask

  task automatic issue_read(input int i);
    bit hit;
    ar_sel   = tbl[i].sel;
    ar_addr  = tbl[i].addr;
    ar_valid = 1'b1;
    exp_r.push_back(i);
    for (int n = 0; ar_valid && !aborted; n++) begin
      @(negedge clk);
      hit = slv_rsp.ar_ready;
      // with MaxTrans reads open no new AR may be taken
      if (rd_issued - rd_done == MaxTrans) begin
        cap_hits++;
        check_val(i, "ar_ready at capacity", 64'd0, 64'(slv_rsp.ar_ready));
      end
      if (hit) begin
        check_val(i, "ar port", 64'(1) << tbl[i].sel, 64'(port_valids(2)));
        check_val(i, "ar addr", 64'(tbl[i].addr), 64'(mst_req[tbl[i].sel].ar.addr));
      end
      if (n == Timeout) begin
        $display("timeout: read %s was never accepted", tbl[i].name);
        errors++;
        aborted = 1'b1;
      end
      @(posedge clk);
      #(DriveDly);
      if (hit) begin
        ar_valid = 1'b0;
        rd_issued++;
      end
    end
  endtask

  task automatic issue_all();
    for (int i = 0; i < NumTests && !aborted; i++) begin
      if (tbl[i].is_wr) begin
        issue_write(i);
      end else begin
        issue_read(i);
      end
    end
  endtask

  // --------------------------------------------------
  // response side for B (is_rd 0) and R (is_rd 1)
  // --------------------------------------------------
  task automatic take_responses(input bit is_rd);
    int          total;
    int          idx;
    logic [63:0] held;
    logic [63:0] exp;
    total = 0;
    for (int i = 0; i < NumTests; i++) begin
      if (tbl[i].is_wr != is_rd) begin
        total++;
      end
    end
    for (int k = 0; k < total && !aborted; k++) begin
      for (int n = 0; !aborted; n++) begin
        @(negedge clk);
        if (resp_pending(is_rd)) begin
          break;
        end
        if (n == Timeout) begin
          $display("timeout: no %s response arrived", is_rd ? "read" : "write");
          errors++;
          aborted = 1'b1;
        end
      end
      if (aborted) begin
        break;
      end
      idx  = is_rd ? exp_r[0] : exp_b[0];
      held = resp_word(is_rd);
      // slave ready stays low, so the response has to hold still
      for (int s = 0; s < tbl[idx].stall; s++) begin
        @(negedge clk);
        check_val(idx, "held response", held, resp_word(is_rd));
      end
      @(posedge clk);
      #(DriveDly);
      set_ready(is_rd, 1'b1);
      @(negedge clk);
      if (is_rd) begin
        exp = 64'({1'b1, tbl[idx].addr ^ (32'(tbl[idx].sel) * 32'h1111_1111), tbl[idx].sel});
      end else begin
        exp = 64'({1'b1, 32'h0, tbl[idx].sel});
      end
      check_val(idx, is_rd ? "r valid/data/resp" : "b valid/resp", exp, resp_word(is_rd));
      @(posedge clk);
      #(DriveDly);
      set_ready(is_rd, 1'b0);
      if (is_rd) begin
        void'(exp_r.pop_front());
        rd_done++;
      end else begin
        void'(exp_b.pop_front());
      end
      $display("%-12s %s", tbl[idx].name, (test_err[idx] == 0) ? "ok" : "FAILED");
    end
  endtask

  // --------------------------------------------------
  // manager port models
  // --------------------------------------------------
  // port p answers writes with resp p and reads with addr ^ p*0x11111111
  initial begin : port_models
    logic [NumPorts-1:0] aw_hs;
    logic [NumPorts-1:0] w_hs;
    logic [NumPorts-1:0] ar_hs;
    logic [NumPorts-1:0] b_hs;
    logic [NumPorts-1:0] r_hs;
    logic [31:0]         ar_seen [NumPorts];
    mst_rsp = '0;
    for (int n = 0; rst_n !== 1'b1 && n < Timeout; n++) begin
      @(negedge clk);
    end
    forever begin
      @(negedge clk);
      for (int p = 0; p < NumPorts; p++) begin
        aw_hs[p]   = mst_req[p].aw_valid & mst_rsp[p].aw_ready;
        w_hs[p]    = mst_req[p].w_valid & mst_rsp[p].w_ready;
        ar_hs[p]   = mst_req[p].ar_valid & mst_rsp[p].ar_ready;
        b_hs[p]    = mst_req[p].b_ready & mst_rsp[p].b_valid;
        r_hs[p]    = mst_req[p].r_ready & mst_rsp[p].r_valid;
        ar_seen[p] = mst_req[p].ar.addr;
      end
      @(posedge clk);
      #(DriveDly);
      for (int p = 0; p < NumPorts; p++) begin
        if (aw_hs[p]) begin
          aw_cnt[p]++;
        end
        if (w_hs[p]) begin
          w_cnt[p]++;
        end
        if (ar_hs[p]) begin
          rd_q[p].push_back(ar_seen[p]);
        end
        if (b_hs[p]) begin
          mst_rsp[p].b_valid = 1'b0;
        end
        if (r_hs[p]) begin
          mst_rsp[p].r_valid = 1'b0;
          void'(rd_q[p].pop_front());
        end
        mst_rsp[p].aw_ready = next_rand_bit();
        mst_rsp[p].w_ready  = next_rand_bit();
        mst_rsp[p].ar_ready = next_rand_bit();
        // a B is owed once both AW and W of a write have arrived
        if (!mst_rsp[p].b_valid && b_sent[p] < aw_cnt[p] && b_sent[p] < w_cnt[p]
            && next_rand_bit()) begin
          mst_rsp[p].b_valid = 1'b1;
          mst_rsp[p].b.resp  = 2'(p);
          b_sent[p]++;
        end
        if (!mst_rsp[p].r_valid && rd_q[p].size() > 0 && next_rand_bit()) begin
          mst_rsp[p].r_valid = 1'b1;
          mst_rsp[p].r.data  = rd_q[p][0] ^ (32'(p) * 32'h1111_1111);
          mst_rsp[p].r.resp  = 2'(p);
        end
      end
    end
  end

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    int failed;
    lfsr      = 32'd32249;
    aw_sel    = '0;
    ar_sel    = '0;
    aw_addr   = '0;
    ar_addr   = '0;
    w_data    = '0;
    w_strb    = '0;
    aw_valid  = 1'b0;
    w_valid   = 1'b0;
    b_ready   = 1'b0;
    ar_valid  = 1'b0;
    r_ready   = 1'b0;
    errors    = 0;
    rd_issued = 0;
    rd_done   = 0;
    cap_hits  = 0;
    aborted   = 1'b0;
    failed    = 0;
    fill_table();

    for (int n = 0; rst_n !== 1'b1 && !aborted; n++) begin
      @(negedge clk);
      if (n == Timeout) begin
        $display("timeout: reset was never released");
        errors++;
        aborted = 1'b1;
      end
    end

    // idle outputs right after reset
    for (int p = 0; p < NumPorts; p++) begin
      check_val(NumTests, $sformatf("port %0d valids and readies", p), 64'd0,
                64'({mst_req[p].aw_valid, mst_req[p].w_valid, mst_req[p].ar_valid,
                     mst_req[p].b_ready, mst_req[p].r_ready}));
    end
    check_val(NumTests, "slave b_valid/r_valid", 64'd0,
              64'({slv_rsp.b_valid, slv_rsp.r_valid}));
    @(posedge clk);
    #(DriveDly);

    fork
      issue_all();
      take_responses(1'b0);
      take_responses(1'b1);
    join

    if (!aborted) begin
      assert (cap_hits > 0) else begin
        $display("the limit of %0d open reads was never reached", MaxTrans);
        errors++;
      end
    end
    for (int i = 0; i < NumTests; i++) begin
      if (test_err[i] != 0) begin
        failed++;
      end
    end
    $display("summary: %0d tests, %0d with errors, %0d errors in total",
             NumTests, failed, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PeriodNs  = 40,
  parameter int RstCycles = 2,
  parameter int DriveNs   = 2
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // release lands just after an edge like every other input
  initial begin
    rst_n_o = 1'b0;
    repeat (RstCycles) @(posedge clk_o);
    #(DriveNs) rst_n_o = 1'b1;
  end

endmodule
